//--- rtl/aluPkg.sv
// operation, condition and flag encodings for the execute block
// opcodes 12 to 15 are the memory ops, retired here as no-ops
package aluPkg;

    // alu operations, 4-bit opcode field
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opMul  = 4'd2,
        opOr   = 4'd3,
        opAnd  = 4'd4,
        opXor  = 4'd5,
        opMovn = 4'd6,
        opMov  = 4'd7,
        opLsr  = 4'd8,
        opLsl  = 4'd9,
        opRor  = 4'd10,
        opCmp  = 4'd11,
        // memory control, not executed
        opAdr  = 4'd12,
        opLdr  = 4'd13,
        opStr  = 4'd14,
        opRsvd = 4'd15
    } opcodeT;

    // condition codes, checked against the stored flags
    typedef enum logic [3:0] {
        condAl = 4'd0,
        // z set
        condEq = 4'd1,
        // z clear and n == v
        condGt = 4'd2,
        // n != v
        condLt = 4'd3,
        condGe = 4'd4,
        // z set or n != v
        condLe = 4'd5,
        // c set and z clear
        condHi = 4'd6,
        condLo = 4'd7,
        condHs = 4'd8
        // 9..15 never execute
    } condT;

    // nzcv, n is the msb
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

endpackage

//--- rtl/instrPkg.sv
// instruction word layout and the structs passed between pipe stages
// immediate is 11 bits so three register fields fit in one word
package instrPkg;

    // field positions in the 32-bit instruction word
    parameter int condMsb = 31;
    parameter int condLsb = 28;
    parameter int opMsb   = 27;
    parameter int opLsb   = 24;
    parameter int sBit    = 23;
    parameter int rdMsb   = 22;
    parameter int rdLsb   = 19;
    parameter int rnMsb   = 18;
    parameter int rnLsb   = 15;
    parameter int rmMsb   = 14;
    parameter int rmLsb   = 11;
    parameter int immMsb  = 10;
    parameter int immLsb  = 0;

    // output of the decoder, held in the first stage register
    typedef struct packed {
        aluPkg::condT   cond;
        aluPkg::opcodeT op;
        logic           setFlags;
        logic [3:0]     rd;
        logic [3:0]     rn;
        logic [3:0]     rm;
        logic [10:0]    imm;
        // class bits
        logic           writesReg;
        logic           usesFlags;
    } decodedT;

    // one entry per retired instruction
    typedef struct packed {
        logic          executed;
        logic          regWrite;
        logic [3:0]    rd;
        logic [31:0]   data;
        aluPkg::flagsT flags;
    } wbT;

endpackage

//--- rtl/stageReg.sv
// pipeline register with a valid bit, payload of any packed type
// payload holds its old value while the input is not valid
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // valid bit, cleared in reset
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
        end
        else
        begin
            outValid <= inValid;
        end
    end

    // data path, no reset value
    always_ff @(posedge clk)
    begin
        if (rstN && inValid)
        begin
            outData <= inData;
        end
    end

endmodule

//--- rtl/instrDecoder.sv
// combinational decode of the instruction word
// reserved opcodes neither write a register nor touch the flags
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]      instrWord,
    output instrPkg::decodedT decoded
);

    import aluPkg::*;
    import instrPkg::*;

    logic   sFlag;
    opcodeT opField;
    logic   isReserved;

    assign sFlag   = instrWord[sBit];
    assign opField = opcodeT'(instrWord[opMsb:opLsb]);

    // adr, ldr, str and 15 are all above cmp
    assign isReserved = (opField > opCmp);

    always_comb
    begin
        // raw fields
        decoded.cond     = condT'(instrWord[condMsb:condLsb]);
        decoded.op       = opField;
        decoded.setFlags = sFlag;
        decoded.rd       = instrWord[rdMsb:rdLsb];
        decoded.rn       = instrWord[rnMsb:rnLsb];
        decoded.rm       = instrWord[rmMsb:rmLsb];
        decoded.imm      = instrWord[immMsb:immLsb];

        // cmp only updates flags
        decoded.writesReg = !isReserved && (opField != opCmp);

        // cmp always sets flags, s bit for the rest
        decoded.usesFlags = (opField == opCmp) || (sFlag && !isReserved);
    end

endmodule

//--- rtl/regFile.sv
// register file, two combinational reads and one clocked write
// a read in the same cycle as a write returns the old value
`timescale 1ns/1ps

module regFile #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [$clog2(regCount)-1:0] rdAddrA,
    input  logic [$clog2(regCount)-1:0] rdAddrB,
    output logic [dataWidth-1:0]        rdDataA,
    output logic [dataWidth-1:0]        rdDataB,
    input  logic                        wrEn,
    input  logic [$clog2(regCount)-1:0] wrAddr,
    input  logic [dataWidth-1:0]        wrData
);

    logic [dataWidth-1:0] regs [regCount];

    // every entry reads zero after reset
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // operand ports, rn and rm
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

//--- rtl/aluCore.sv
// combinational datapath for the twelve alu operations
// shift amount is imm[4:0] for 32 bits, mul keeps the low word
`timescale 1ns/1ps

module aluCore #(
    parameter int dataWidth = 32
) (
    input  aluPkg::opcodeT       op,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic [10:0]          imm,
    input  aluPkg::flagsT        flagsIn,
    output logic [dataWidth-1:0] result,
    output aluPkg::flagsT        flagsOut
);

    import aluPkg::*;

    localparam int shiftBits = $clog2(dataWidth);
    localparam int msb       = dataWidth - 1;

    logic [shiftBits-1:0]   shAmt;
    // extra bit holds the carry out
    logic [dataWidth:0]     addSum;
    logic [dataWidth:0]     subDiff;
    logic                   addOvf;
    logic                   subOvf;
    logic [dataWidth-1:0]   mulLow;
    // {carry, result}
    logic [dataWidth:0]     lslWide;
    // {result, carry}
    logic [dataWidth:0]     lsrWide;
    logic [2*dataWidth-1:0] rorWide;
    logic                   opKnown;

    assign shAmt = imm[shiftBits-1:0];

    // a + b, carry in bit dataWidth
    assign addSum = {1'b0, opA} + {1'b0, opB};

    // a - b as a + ~b + 1, carry set means no borrow
    assign subDiff = {1'b0, opA} + {1'b0, ~opB} + {{dataWidth{1'b0}}, 1'b1};

    // signed overflow
    assign addOvf = (opA[msb] == opB[msb]) && (addSum[msb] != opA[msb]);
    assign subOvf = (opA[msb] != opB[msb]) && (subDiff[msb] != opA[msb]);

    // truncated product
    assign mulLow = opA * opB;

    // shifts keep the last bit moved out next to the result
    assign lslWide = {1'b0, opB} << shAmt;
    assign lsrWide = {opB, 1'b0} >> shAmt;
    assign rorWide = {opB, opB} >> shAmt;

    always_comb
    begin
        result   = '0;
        flagsOut = flagsIn;
        opKnown  = 1'b1;

        case (op)
            opAdd:
            begin
                result     = addSum[msb:0];
                flagsOut.c = addSum[dataWidth];
                flagsOut.v = addOvf;
            end
            // cmp computes the same difference, rd is not written
            opSub, opCmp:
            begin
                result     = subDiff[msb:0];
                flagsOut.c = subDiff[dataWidth];
                flagsOut.v = subOvf;
            end
            opMul:  result = mulLow;
            opOr:   result = opA | opB;
            opAnd:  result = opA & opB;
            opXor:  result = opA ^ opB;
            // immediate, zero extended
            opMovn: result = {{(dataWidth - 11){1'b0}}, imm};
            opMov:  result = opB;
            opLsr:
            begin
                result = lsrWide[dataWidth:1];
                // zero shift keeps c
                if (shAmt != '0)
                begin
                    flagsOut.c = lsrWide[0];
                end
            end
            opLsl:
            begin
                result = lslWide[msb:0];
                if (shAmt != '0)
                begin
                    flagsOut.c = lslWide[dataWidth];
                end
            end
            opRor:
            begin
                result = rorWide[msb:0];
                // last bit rotated out lands in the msb
                if (shAmt != '0)
                begin
                    flagsOut.c = rorWide[msb];
                end
            end
            default:
            begin
                // memory ops, nothing computed
                opKnown = 1'b0;
            end
        endcase

        // n and z follow the result
        if (opKnown)
        begin
            flagsOut.n = result[msb];
            flagsOut.z = (result == '0);
        end
    end

endmodule

//--- rtl/executeUnit.sv
// second stage, condition check, flag register, alu and writeback
// condition is checked against the stored flags, not the new ones
`timescale 1ns/1ps

module executeUnit #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    input  instrPkg::decodedT           inInstr,
    output logic [$clog2(regCount)-1:0] rdAddrA,
    output logic [$clog2(regCount)-1:0] rdAddrB,
    input  logic [dataWidth-1:0]        rdDataA,
    input  logic [dataWidth-1:0]        rdDataB,
    output logic                        wrEn,
    output logic [$clog2(regCount)-1:0] wrAddr,
    output logic [dataWidth-1:0]        wrData,
    output instrPkg::wbT                wbOut
);

    import aluPkg::*;

    flagsT                flagsQ;
    flagsT                aluFlags;
    flagsT                flagsNext;
    logic [dataWidth-1:0] aluResult;
    logic                 condPass;
    logic                 flagLoad;

    // operands straight from the register file
    assign rdAddrA = inInstr.rn;
    assign rdAddrB = inInstr.rm;

    // condition table
    always_comb
    begin
        case (inInstr.cond)
            condAl:  condPass = 1'b1;
            condEq:  condPass = flagsQ.z;
            condGt:  condPass = !flagsQ.z && (flagsQ.n == flagsQ.v);
            condLt:  condPass = (flagsQ.n != flagsQ.v);
            condGe:  condPass = (flagsQ.n == flagsQ.v);
            condLe:  condPass = flagsQ.z || (flagsQ.n != flagsQ.v);
            condHi:  condPass = flagsQ.c && !flagsQ.z;
            condLo:  condPass = !flagsQ.c;
            condHs:  condPass = flagsQ.c;
            default: condPass = 1'b0;
        endcase
    end

    aluCore #(
        .dataWidth(dataWidth)
    ) u_aluCore (
        .op      (inInstr.op),
        .opA     (rdDataA),
        .opB     (rdDataB),
        .imm     (inInstr.imm),
        .flagsIn (flagsQ),
        .result  (aluResult),
        .flagsOut(aluFlags)
    );

    // flags move only for an executed flag-setting instruction
    assign flagLoad  = inValid && condPass && inInstr.usesFlags;
    assign flagsNext = flagLoad ? aluFlags : flagsQ;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            flagsQ <= '0;
        end
        else
        begin
            flagsQ <= flagsNext;
        end
    end

    // register write, seen by the next instruction in this stage
    assign wrEn   = inValid && condPass && inInstr.writesReg;
    assign wrAddr = inInstr.rd;
    assign wrData = aluResult;

    // wb reports the flags as they stand after this instruction
    always_comb
    begin
        wbOut.executed = condPass;
        wbOut.regWrite = inInstr.writesReg;
        wbOut.rd       = inInstr.rd;
        wbOut.data     = aluResult;
        wbOut.flags    = flagsNext;
    end

endmodule

//--- rtl/aluSubsystem.sv
// two-stage execute block, fixed latency of 2 cycles
// no back-pressure, wbValid is a single-cycle pulse per instruction
`timescale 1ns/1ps

module aluSubsystem #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         instrValid,
    input  logic [31:0]  instrWord,
    output logic         wbValid,
    output instrPkg::wbT wb
);

    import instrPkg::*;

    decodedT                     decodedWord;
    decodedT                     decodeData;
    logic                        decodeValid;
    logic [$clog2(regCount)-1:0] rdAddrA;
    logic [$clog2(regCount)-1:0] rdAddrB;
    logic [dataWidth-1:0]        rdDataA;
    logic [dataWidth-1:0]        rdDataB;
    logic                        wrEn;
    logic [$clog2(regCount)-1:0] wrAddr;
    logic [dataWidth-1:0]        wrData;
    wbT                          wbNext;

    instrDecoder u_instrDecoder (
        .instrWord(instrWord),
        .decoded  (decodedWord)
    );

    // stage 1, decoded instruction
    stageReg #(
        .payloadT(decodedT)
    ) u_decodeStage (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (instrValid),
        .inData  (decodedWord),
        .outValid(decodeValid),
        .outData (decodeData)
    );

    regFile #(
        .dataWidth(dataWidth),
        .regCount (regCount)
    ) u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    executeUnit #(
        .dataWidth(dataWidth),
        .regCount (regCount)
    ) u_executeUnit (
        .clk    (clk),
        .rstN   (rstN),
        .inValid(decodeValid),
        .inInstr(decodeData),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wbOut  (wbNext)
    );

    // stage 2, writeback report
    stageReg #(
        .payloadT(wbT)
    ) u_wbStage (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (decodeValid),
        .inData  (wbNext),
        .outValid(wbValid),
        .outData (wb)
    );

endmodule

//--- test/aluModel.svh
// reference model of the execute block, included inside the testbench module
// state advances in issue order, expects aluPkg and instrPkg already imported
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

    logic [31:0] modelRegs [16];
    flagsT       modelFlags;
    // expected writebacks and the issue edge of each instruction
    wbT          expQ [$];
    int          expCycleQ [$];

    // condition table on the stored flags
    function automatic logic condHolds(input logic [3:0] cond, input flagsT f);
        case (cond)
            4'd0: return 1'b1;
            4'd1: return f.z;
            4'd2: return !f.z && (f.n == f.v);
            4'd3: return f.n != f.v;
            4'd4: return f.n == f.v;
            4'd5: return f.z || (f.n != f.v);
            4'd6: return f.c && !f.z;
            4'd7: return !f.c;
            4'd8: return f.c;
            default: return 1'b0;
        endcase
    endfunction

    task automatic modelReset;
        for (int i = 0; i < 16; i++)
        begin
            modelRegs[i] = '0;
        end
        modelFlags = '0;
        expQ.delete();
        expCycleQ.delete();
    endtask

    task automatic modelApply(input logic [31:0] word, input int issueCycle);
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [32:0] sWide;
        int          sh;
        logic        pass;
        flagsT       nf;
        wbT          e;
        op  = word[27:24];
        a   = modelRegs[word[18:15]];
        b   = modelRegs[word[14:11]];
        sh  = word[4:0];
        nf  = modelFlags;
        res = '0;
        case (op)
            4'd0:
            begin
                res   = a + b;
                // wrap below a means carry out
                nf.c  = (res < a);
                sWide = {a[31], a} + {b[31], b};
                nf.v  = sWide[32] != sWide[31];
            end
            4'd1, 4'd11:
            begin
                res   = a - b;
                nf.c  = (a >= b);
                sWide = {a[31], a} - {b[31], b};
                nf.v  = sWide[32] != sWide[31];
            end
            4'd2: res = a * b;
            4'd3: res = a | b;
            4'd4: res = a & b;
            4'd5: res = a ^ b;
            4'd6: res = {21'd0, word[10:0]};
            4'd7: res = b;
            4'd8:
            begin
                res = b >> sh;
                if (sh != 0)
                    nf.c = b[sh-1];
            end
            4'd9:
            begin
                res = b << sh;
                if (sh != 0)
                    nf.c = b[32-sh];
            end
            4'd10:
            begin
                res = (b >> sh) | (b << (32 - sh));
                if (sh != 0)
                    nf.c = b[sh-1];
            end
            default: res = '0;
        endcase
        if (op < 4'd12)
        begin
            nf.n = res[31];
            nf.z = (res == 32'd0);
        end
        pass = condHolds(word[31:28], modelFlags);
        // cmp always sets flags, reserved codes never do
        if (pass && ((op == 4'd11) || (word[23] && op < 4'd12)))
            modelFlags = nf;
        if (pass && op < 4'd11)
            modelRegs[word[22:19]] = res;
        e.executed = pass;
        e.regWrite = (op < 4'd11);
        e.rd       = word[22:19];
        e.data     = res;
        e.flags    = modelFlags;
        expQ.push_back(e);
        expCycleQ.push_back(issueCycle);
    endtask

`endif

//--- test/tbAluSubsystem.sv
// testbench for the two-stage execute block, seeded random stimulus
// every writeback is compared with the included model, latency must be 2
`timescale 1ns/1ps

module tbAluSubsystem;

    import aluPkg::*;
    import instrPkg::*;

    localparam int drainLimit = 40;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instrWord;
    logic        wbValid;
    wbT          wb;

    int seed = 75942;
    int cycleCount = 0;
    int errorCount = 0;
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;
    wbT expWb;
    int expIssue;

    `include "aluModel.svh"

    aluSubsystem #(
        .dataWidth(32),
        .regCount (16)
    ) u_aluSubsystem (
        .clk       (clk),
        .rstN      (rstN),
        .instrValid(instrValid),
        .instrWord (instrWord),
        .wbValid   (wbValid),
        .wb        (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // rising edges seen so far
    always @(posedge clk)
        cycleCount++;

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errorCount++;
        end
    endtask

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge clk)
    begin
        if (wbValid === 1'b1)
        begin
            if (expQ.size() == 0)
            begin
                $display("writeback seen with no instruction outstanding, cycle %0d",
                         cycleCount);
                errorCount++;
            end
            else
            begin
                expWb    = expQ.pop_front();
                expIssue = expCycleQ.pop_front();
                checkValue("wb latency", expIssue + 2, cycleCount);
                checkValue("wb.executed", expWb.executed, wb.executed);
                checkValue("wb.regWrite", expWb.regWrite, wb.regWrite);
                checkValue("wb.rd", expWb.rd, wb.rd);
                checkValue("wb.data", expWb.data, wb.data);
                checkValue("wb.flags", expWb.flags, wb.flags);
            end
        end
    end

    function automatic logic [31:0] makeWord(input logic [3:0] cond, input logic [3:0] op,
                                             input logic [3:0] rd, input logic [3:0] rn,
                                             input logic [3:0] rm, input logic [10:0] imm);
        return {cond, op, 1'b0, rd, rn, rm, imm};
    endfunction

    // s, registers and imm random
    function automatic logic [31:0] randWord(input logic [3:0] cond, input logic [3:0] op);
        logic [31:0] r;
        r = $random(seed);
        return {cond, op, r[23:0]};
    endfunction

    task automatic issue(input logic [31:0] word);
        @(negedge clk);
        instrValid = 1'b1;
        instrWord  = word;
        // issue edge is the rising edge just passed, the word is taken at the next one
        modelApply(word, cycleCount);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            instrValid = 1'b0;
            instrWord  = $random(seed);
        end
    endtask

    task automatic drainAndReport(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (expQ.size() != 0 && waited < drainLimit)
        begin
            idle(1);
            waited++;
        end
        if (expQ.size() != 0)
        begin
            $display("timeout in %s, %0d writebacks missing", name, expQ.size());
            $display("Result: FAILED");
            $finish;
        end
        // a few quiet cycles catch stray writebacks
        idle(3);
        if (errorCount == testErrors)
        begin
            passCount++;
            $display("test %s: pass", name);
        end
        else
        begin
            failCount++;
            $display("test %s: fail, %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] w;
        logic [3:0]  prevRd;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instrWord  = '0;
        modelReset();
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        // reset: quiet outputs, then every register reads zero
        repeat (8)
        begin
            @(negedge clk);
            checkValue("wbValid", 1'b0, wbValid);
        end
        for (int i = 0; i < 16; i++)
            issue(makeWord(4'd0, 4'd7, 4'(i), 4'(i), 4'(i), 11'd0));
        drainAndReport("reset");

        // spread bits over all registers, movn then ror
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            issue(makeWord(4'd0, 4'd6, 4'(i), 4'(i), 4'(i), r[10:0]));
            issue(makeWord(4'd0, 4'd10, 4'(i), 4'(i), 4'(i), r[21:11]));
        end
        for (int i = 0; i < 144; i++)
            issue(randWord(4'd0, 4'(i % 12)));
        drainAndReport("operations");

        // each condition right after a cmp
        for (int round = 0; round < 4; round++)
        begin
            for (int c = 0; c < 16; c++)
            begin
                r = $random(seed);
                issue(randWord(4'd0, 4'd11));
                issue(randWord(4'(c), 4'(r % 12)));
            end
        end
        drainAndReport("conditions");

        // dependent chain, one instruction per cycle
        prevRd = 4'd0;
        for (int i = 0; i < 80; i++)
        begin
            r = $random(seed);
            w = randWord(r[8] ? 4'd0 : 4'(r[7:4] % 9), 4'(r[31:16] % 12));
            if (r[9])
                w[18:15] = prevRd;
            else
                w[14:11] = prevRd;
            issue(w);
            prevRd = w[22:19];
        end
        drainAndReport("back-to-back");

        // reserved opcodes mixed in, random idle gaps
        for (int i = 0; i < 60; i++)
        begin
            r = $random(seed);
            issue(randWord(r[8] ? 4'd0 : 4'(r[7:4] % 9), r[3:0]));
            idle(int'(r[13:12]));
        end
        drainAndReport("reserved and gaps");

        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+test
rtl/aluPkg.sv
rtl/instrPkg.sv
rtl/stageReg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/aluCore.sv
rtl/executeUnit.sv
rtl/aluSubsystem.sv
test/tbAluSubsystem.sv

//--- Makefile
# Verilator build and run for the execute block testbench
VERILATOR ?= verilator
TOP       ?= tbAluSubsystem
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard test/*.svh)
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result line in log"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
